/* corr_pkg.sv */
//////////////////////////////
// Correlator sizes and packet layout
// Command opcodes and transmit states
//////////////////////////////

package corr_pkg;

	// Detector lines and counter geometry
	localparam int NUM_LINES = 4;
	localparam int RESOLUTION = 16;
	localparam int NUM_LAGS = 2;
	localparam int WORDS_PER_LINE = 1 + NUM_LAGS;
	localparam int NUM_WORDS = NUM_LINES * WORDS_PER_LINE;

	// Packet is header, flags, then two bytes per counter word
	localparam int PACKET_BYTES = 2 + NUM_WORDS * 2;
	localparam int DATA_BYTES = PACKET_BYTES - 2;
	localparam int BYTE_IDX_W = $clog2(DATA_BYTES);
	localparam logic [7:0] PACKET_HEADER = 8'hA5;

	// Upper nibble of a command byte
	typedef enum logic [3:0] {
		OP_NOP = 4'd0,
		OP_START = 4'd1,
		OP_STOP = 4'd2,
		OP_CLEAR = 4'd3,
		OP_SET_INVERT = 4'd4,
		OP_SET_EDGE = 4'd5
	} cmd_op_t;

	typedef enum logic [1:0] {
		IDLE,
		HEADER,
		FLAGS,
		DATA
	} tx_state_t;

endpackage

/* line_conditioner.sv */
//////////////////////////////
// Detector line input stage
// Sync, inversion, level or edge pulse
//////////////////////////////

`timescale 1ns/1ps

module line_conditioner (
	input  logic                           intclk,
	input  logic                           rst_n,
	input  logic [corr_pkg::NUM_LINES-1:0] line_in,
	input  logic [corr_pkg::NUM_LINES-1:0] invert_mask,
	input  logic [corr_pkg::NUM_LINES-1:0] edge_mask,
	output logic [corr_pkg::NUM_LINES-1:0] pulse
);
	import corr_pkg::*;

	logic [NUM_LINES-1:0] sync_0;
	logic [NUM_LINES-1:0] sync_1;
	logic [NUM_LINES-1:0] level;
	logic [NUM_LINES-1:0] prev_level;
	logic [NUM_LINES-1:0] rise;

	// Conditioned level after the mask
	assign level = sync_1 ^ invert_mask;
	assign rise = level & ~prev_level;

	// Two stage synchroniser on the raw detector lines
	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			sync_0 <= '0;
			sync_1 <= '0;
		end else begin
			sync_0 <= line_in;
			sync_1 <= sync_0;
		end
	end

	// Edge lines give one cycle per rising level, others pass the level
	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			prev_level <= '0;
			pulse <= '0;
		end else begin
			prev_level <= level;
			pulse <= (rise & edge_mask) | (level & ~edge_mask);
		end
	end

endmodule

/* cmd_parser.sv */
//////////////////////////////
// Command byte decoder
// Integration level, clear and dump, mode masks
//////////////////////////////

`timescale 1ns/1ps

module cmd_parser (
	input  logic                           intclk,
	input  logic                           rst_n,
	input  logic [7:0]                     rx_byte,
	input  logic                           rx_strobe,
	input  logic                           tx_active,
	output logic                           integrating,
	output logic                           clear,
	output logic                           dump,
	output logic [corr_pkg::NUM_LINES-1:0] invert_mask,
	output logic [corr_pkg::NUM_LINES-1:0] edge_mask
);
	import corr_pkg::*;

	cmd_op_t              op;
	logic [NUM_LINES-1:0] mask_arg;
	logic                 start_ok;

	assign op = cmd_op_t'(rx_byte[7:4]);
	assign mask_arg = rx_byte[NUM_LINES-1:0];

	// No new window while a packet is pending or on the wire
	assign start_ok = !tx_active && !dump;

	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			integrating <= 1'b0;
			clear <= 1'b0;
			dump <= 1'b0;
			invert_mask <= '0;
			edge_mask <= '0;
		end else begin
			clear <= 1'b0;
			dump <= 1'b0;
			if (rx_strobe) begin
				case (op)
					OP_NOP: begin
					end
					OP_START: begin
						if (start_ok)
							integrating <= 1'b1;
					end
					OP_STOP: begin
						// dump only on a real end of window
						if (integrating) begin
							integrating <= 1'b0;
							dump <= 1'b1;
						end
					end
					OP_CLEAR: begin
						clear <= 1'b1;
					end
					OP_SET_INVERT: begin
						invert_mask <= mask_arg;
					end
					OP_SET_EDGE: begin
						edge_mask <= mask_arg;
					end
					default: begin
					end
				endcase
			end
		end
	end

endmodule

/* line_channel.sv */
//////////////////////////////
// Per line pulse and lag counters
// Saturating, sticky overflow
//////////////////////////////

`timescale 1ns/1ps

module line_channel (
	input  logic                                              intclk,
	input  logic                                              rst_n,
	input  logic                                              pulse_in,
	input  logic                                              integrating,
	input  logic                                              clear,
	output logic [corr_pkg::RESOLUTION-1:0]                   count,
	output logic [corr_pkg::NUM_LAGS*corr_pkg::RESOLUTION-1:0] lag_count,
	output logic                                              overflow
);
	import corr_pkg::*;

	// hist[k] holds the pulse from k+1 cycles ago
	logic [NUM_LAGS-1:0]            hist;
	logic [RESOLUTION-1:0]          count_next;
	logic [NUM_LAGS*RESOLUTION-1:0] lag_next;
	logic [NUM_LAGS:0]              sat_now;
	logic                           hit;

	assign hit = integrating & pulse_in;

	always_comb begin
		count_next = count;
		lag_next = lag_count;
		sat_now = '0;
		if (hit && !(&count)) begin
			count_next = count + 1'b1;
			sat_now[0] = &count_next;
		end
		for (int k = 0; k < NUM_LAGS; k++) begin
			// Coincidence with the sample k+1 cycles back
			if (hit && hist[k] && !(&lag_count[k*RESOLUTION +: RESOLUTION])) begin
				lag_next[k*RESOLUTION +: RESOLUTION] =
					lag_count[k*RESOLUTION +: RESOLUTION] + 1'b1;
				sat_now[k + 1] = &lag_next[k*RESOLUTION +: RESOLUTION];
			end
		end
	end

	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			hist <= '0;
			count <= '0;
			lag_count <= '0;
			overflow <= 1'b0;
		end else if (clear) begin
			hist <= '0;
			count <= '0;
			lag_count <= '0;
			overflow <= 1'b0;
		end else begin
			// history runs whether or not integrating
			hist <= {hist[NUM_LAGS-2:0], pulse_in};
			count <= count_next;
			lag_count <= lag_next;
			overflow <= overflow | (|sat_now);
		end
	end

endmodule

/* packet_tx.sv */
//////////////////////////////
// Result packet sender
// Snapshot on dump, one byte per free cycle
//////////////////////////////

`timescale 1ns/1ps

module packet_tx (
	input  logic                                               intclk,
	input  logic                                               rst_n,
	input  logic                                               dump,
	input  logic                                               tx_busy,
	input  logic [corr_pkg::NUM_WORDS*corr_pkg::RESOLUTION-1:0] counts,
	input  logic [corr_pkg::NUM_LINES-1:0]                      overflow,
	output logic [7:0]                                         tx_byte,
	output logic                                               tx_strobe,
	output logic                                               tx_active
);
	import corr_pkg::*;

	tx_state_t             state;
	logic [BYTE_IDX_W-1:0] byte_idx;
	logic [RESOLUTION-1:0] snap [NUM_WORDS];
	logic [NUM_LINES-1:0]  flags_snap;
	logic [RESOLUTION-1:0] cur_word;
	logic                  last_byte;

	assign tx_active = (state != IDLE);
	assign tx_strobe = tx_active && !tx_busy;

	// Two bytes per word, high byte on even index
	assign cur_word = snap[byte_idx[BYTE_IDX_W-1:1]];
	assign last_byte = (byte_idx == BYTE_IDX_W'(DATA_BYTES - 1));

	// Counter snapshot taken when a packet starts
	always_ff @(posedge intclk) begin
		if (state == IDLE && dump) begin
			for (int w = 0; w < NUM_WORDS; w++)
				snap[w] <= counts[w*RESOLUTION +: RESOLUTION];
			flags_snap <= overflow;
		end
	end

	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			byte_idx <= '0;
		end else begin
			case (state)
				IDLE: begin
					byte_idx <= '0;
					if (dump)
						state <= HEADER;
				end
				HEADER: begin
					if (!tx_busy)
						state <= FLAGS;
				end
				FLAGS: begin
					if (!tx_busy)
						state <= DATA;
				end
				DATA: begin
					// busy holds the current byte
					if (!tx_busy) begin
						if (last_byte) begin
							state <= IDLE;
							byte_idx <= '0;
						end else begin
							byte_idx <= byte_idx + 1'b1;
						end
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	always_comb begin
		case (state)
			HEADER: tx_byte = PACKET_HEADER;
			FLAGS: tx_byte = 8'(flags_snap);
			DATA: begin
				if (byte_idx[0])
					tx_byte = cur_word[7:0];
				else
					tx_byte = cur_word[RESOLUTION-1 -: 8];
			end
			default: tx_byte = 8'h00;
		endcase
	end

endmodule

/* corr_top.sv */
//////////////////////////////
// Pulse correlator top level
// Parser, conditioner, channels, packet sender
//////////////////////////////

`timescale 1ns/1ps

module corr_top (
	input  logic                           intclk,
	input  logic                           rst_n,
	input  logic [7:0]                     rx_byte,
	input  logic                           rx_strobe,
	input  logic [corr_pkg::NUM_LINES-1:0] line_in,
	input  logic                           tx_busy,
	output logic [7:0]                     tx_byte,
	output logic                           tx_strobe,
	output logic                           tx_active,
	output logic                           integrating,
	output logic [corr_pkg::NUM_LINES-1:0] overflow
);
	import corr_pkg::*;

	logic                            clear;
	logic                            dump;
	logic [NUM_LINES-1:0]            invert_mask;
	logic [NUM_LINES-1:0]            edge_mask;
	logic [NUM_LINES-1:0]            pulse;
	logic [NUM_WORDS*RESOLUTION-1:0] counts;

	cmd_parser u_parser (
		.intclk      (intclk),
		.rst_n       (rst_n),
		.rx_byte     (rx_byte),
		.rx_strobe   (rx_strobe),
		.tx_active   (tx_active),
		.integrating (integrating),
		.clear       (clear),
		.dump        (dump),
		.invert_mask (invert_mask),
		.edge_mask   (edge_mask)
	);

	line_conditioner u_cond (
		.intclk      (intclk),
		.rst_n       (rst_n),
		.line_in     (line_in),
		.invert_mask (invert_mask),
		.edge_mask   (edge_mask),
		.pulse       (pulse)
	);

	// Word order per line is count, lag 1, lag 2
	for (genvar i = 0; i < NUM_LINES; i++) begin : g_line
		line_channel u_channel (
			.intclk      (intclk),
			.rst_n       (rst_n),
			.pulse_in    (pulse[i]),
			.integrating (integrating),
			.clear       (clear),
			.count       (counts[i*WORDS_PER_LINE*RESOLUTION +: RESOLUTION]),
			.lag_count   (counts[(i*WORDS_PER_LINE+1)*RESOLUTION +: NUM_LAGS*RESOLUTION]),
			.overflow    (overflow[i])
		);
	end

	packet_tx u_tx (
		.intclk    (intclk),
		.rst_n     (rst_n),
		.dump      (dump),
		.tx_busy   (tx_busy),
		.counts    (counts),
		.overflow  (overflow),
		.tx_byte   (tx_byte),
		.tx_strobe (tx_strobe),
		.tx_active (tx_active)
	);

endmodule

/* corr_props.sv */
//////////////////////////////
// Output protocol assertions
// Bound into the correlator top
//////////////////////////////

`timescale 1ns/1ps

module corr_props (
	input logic                           intclk,
	input logic                           rst_n,
	input logic                           tx_busy,
	input logic                           tx_strobe,
	input logic                           tx_active,
	input logic [7:0]                     tx_byte,
	input logic                           integrating,
	input logic                           clear,
	input logic [corr_pkg::NUM_LINES-1:0] overflow,
	input corr_pkg::tx_state_t            state
);
	import corr_pkg::*;

	// Back-pressure holds the byte on the wire inside a packet
	a_hold: assert property (@(posedge intclk) disable iff (!rst_n)
		(tx_active && tx_busy) |=> (tx_active && $stable(tx_byte)))
		else $error("byte changed or packet ended under tx_busy");

	// Overflow bits are sticky until clear
	a_overflow: assert property (@(posedge intclk) disable iff (!rst_n)
		!clear |=> (($past(overflow) & ~overflow) == '0))
		else $error("overflow bit dropped without a clear");

	a_first_byte: assert property (@(posedge intclk) disable iff (!rst_n)
		(state == HEADER) |-> !integrating)
		else $error("integration running during the packet header");

endmodule

/* corr_tb.sv */
//////////////////////////////
// Correlator testbench
// Random windows, line model, packet checks
//////////////////////////////

`timescale 1ns/1ps

module corr_tb;
	import corr_pkg::*;

	localparam int BYTE_TIMEOUT = 60;
	localparam int GUARD = 4;

	logic                 intclk;
	logic                 rst_n;
	logic [7:0]           rx_byte;
	logic                 rx_strobe;
	logic [NUM_LINES-1:0] line_in;
	logic                 tx_busy;
	logic [7:0]           tx_byte;
	logic                 tx_strobe;
	logic                 tx_active;
	logic                 integrating;
	logic [NUM_LINES-1:0] overflow;

	integer seed;
	int     errors;
	int     checks;
	int     tests;
	int     failed;
	int     test_err0;
	int     byte_pos;

	// Reference model of the conditioned lines and counters
	logic [RESOLUTION-1:0] m_count [NUM_LINES];
	logic [RESOLUTION-1:0] m_lag [NUM_LINES][NUM_LAGS];
	logic [NUM_LINES-1:0]  m_hist [NUM_LAGS];
	logic [NUM_LINES-1:0]  m_prev;
	logic [NUM_LINES-1:0]  m_ovf;
	logic [NUM_LINES-1:0]  m_inv;
	logic [NUM_LINES-1:0]  m_edge;
	logic [7:0]            exp_q [$];

	corr_top dut0 (
		.intclk      (intclk),
		.rst_n       (rst_n),
		.rx_byte     (rx_byte),
		.rx_strobe   (rx_strobe),
		.line_in     (line_in),
		.tx_busy     (tx_busy),
		.tx_byte     (tx_byte),
		.tx_strobe   (tx_strobe),
		.tx_active   (tx_active),
		.integrating (integrating),
		.overflow    (overflow)
	);

	bind corr_top corr_props u_props (
		.intclk      (intclk),
		.rst_n       (rst_n),
		.tx_busy     (tx_busy),
		.tx_strobe   (tx_strobe),
		.tx_active   (tx_active),
		.tx_byte     (tx_byte),
		.integrating (integrating),
		.clear       (clear),
		.overflow    (overflow),
		.state       (u_tx.state)
	);

	initial begin
		intclk = 1'b0;
		forever #2 intclk = ~intclk;
	end

	// Packet bytes are compared as they leave the DUT
	always @(posedge intclk) begin
		if (rst_n && tx_strobe) begin
			checks++;
			assert (exp_q.size() != 0) else begin
				$display("Packet byte %h sent while no packet was due", tx_byte);
				errors++;
			end
			if (exp_q.size() != 0) begin
				assert (tx_byte == exp_q[0]) else begin
					$display("Mismatch tx_byte byte %0d: got %h, expected %h",
						byte_pos, tx_byte, exp_q[0]);
					errors++;
				end
				void'(exp_q.pop_front());
				byte_pos++;
			end
		end
	end

	function automatic logic [RESOLUTION-1:0] sat_inc(input logic [RESOLUTION-1:0] v);
		return (v == '1) ? v : v + 1'b1;
	endfunction

	task automatic check_val(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got == exp) else begin
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	// Falling edge drive with random back-pressure
	task automatic step();
		@(negedge intclk);
		rx_strobe = 1'b0;
		tx_busy = (($random(seed) % 3) == 0);
	endtask

	task automatic clear_model();
		for (int i = 0; i < NUM_LINES; i++) begin
			m_count[i] = '0;
			for (int k = 0; k < NUM_LAGS; k++)
				m_lag[i][k] = '0;
		end
		m_ovf = '0;
	endtask

	task automatic send_cmd(input cmd_op_t op, input logic [3:0] arg);
		step();
		rx_byte = {op, arg};
		rx_strobe = 1'b1;
		if (op == OP_SET_INVERT) begin
			m_inv = arg[NUM_LINES-1:0];
			line_in = m_inv;
		end else if (op == OP_SET_EDGE) begin
			m_edge = arg[NUM_LINES-1:0];
		end else if (op == OP_CLEAR) begin
			clear_model();
		end
		step();
	endtask

	task automatic model_sample(input logic [NUM_LINES-1:0] v);
		logic [NUM_LINES-1:0] c;
		logic [NUM_LINES-1:0] p;
		c = v ^ m_inv;
		p = (c & ~m_prev & m_edge) | (c & ~m_edge);
		m_prev = c;
		for (int i = 0; i < NUM_LINES; i++) begin
			if (p[i]) begin
				m_count[i] = sat_inc(m_count[i]);
				if (&m_count[i])
					m_ovf[i] = 1'b1;
				for (int k = 0; k < NUM_LAGS; k++) begin
					if (m_hist[k][i]) begin
						m_lag[i][k] = sat_inc(m_lag[i][k]);
						if (&m_lag[i][k])
							m_ovf[i] = 1'b1;
					end
				end
			end
		end
		for (int k = NUM_LAGS - 1; k > 0; k--)
			m_hist[k] = m_hist[k-1];
		m_hist[0] = p;
	endtask

	task automatic push_word(input logic [RESOLUTION-1:0] w);
		exp_q.push_back(w[RESOLUTION-1 -: 8]);
		exp_q.push_back(w[7:0]);
	endtask

	task automatic wait_packet(input bit inject);
		int idle;
		int last;
		int injected;
		idle = 0;
		injected = 0;
		last = exp_q.size();
		while (exp_q.size() != 0 && idle < BYTE_TIMEOUT) begin
			step();
			// A START during the packet must not reopen a window
			if (injected != 0)
				check_val("integrating", 32'(integrating), 32'h0);
			// Commands that must be ignored while the packet is out
			if (inject && injected == 0 && exp_q.size() <= 20) begin
				rx_byte = {OP_START, 4'h0};
				rx_strobe = 1'b1;
				injected = 1;
			end else if (inject && injected == 1 && exp_q.size() <= 8) begin
				rx_byte = {OP_STOP, 4'h0};
				rx_strobe = 1'b1;
				injected = 2;
			end
			if (exp_q.size() != last) begin
				idle = 0;
				last = exp_q.size();
			end else begin
				idle++;
			end
		end
		checks++;
		assert (exp_q.size() == 0) else begin
			$display("Timeout: packet stalled with %0d bytes still due", exp_q.size());
			errors++;
			exp_q.delete();
		end
		step();
	endtask

	task automatic window_packet(input int len, input bit ones0, input bit inject);
		logic [31:0]          r;
		logic [NUM_LINES-1:0] v;
		send_cmd(OP_START, 4'h0);
		m_prev = '0;
		for (int k = 0; k < NUM_LAGS; k++)
			m_hist[k] = '0;
		// Guards hold the conditioned level low around the window
		for (int t = 0; t < GUARD; t++) begin
			step();
			line_in = m_inv;
		end
		for (int t = 0; t < len; t++) begin
			step();
			r = $random(seed);
			v = r[NUM_LINES-1:0];
			if (ones0)
				v[0] = ~m_inv[0];
			line_in = v;
			model_sample(v);
		end
		for (int t = 0; t < GUARD; t++) begin
			step();
			line_in = m_inv;
		end
		send_cmd(OP_STOP, 4'h0);
		byte_pos = 0;
		exp_q.push_back(PACKET_HEADER);
		exp_q.push_back(8'(m_ovf));
		for (int i = 0; i < NUM_LINES; i++) begin
			push_word(m_count[i]);
			for (int k = 0; k < NUM_LAGS; k++)
				push_word(m_lag[i][k]);
		end
		wait_packet(inject);
		check_val("overflow", 32'(overflow), 32'(m_ovf));
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == test_err0) begin
			$display("test %0d %s: pass", tests, name);
		end else begin
			failed++;
			$display("test %0d %s: fail", tests, name);
		end
		test_err0 = errors;
	endtask

	initial begin
		logic [31:0] r;
		seed = 11315;
		rst_n = 1'b0;
		rx_byte = 8'h00;
		rx_strobe = 1'b0;
		line_in = '0;
		tx_busy = 1'b0;
		m_inv = '0;
		m_edge = '0;
		m_prev = '0;
		clear_model();
		repeat (10) step();
		rst_n = 1'b1;
		repeat (3) step();

		window_packet(200, 1'b0, 1'b0);
		end_test("level mode window");

		r = $random(seed);
		send_cmd(OP_CLEAR, 4'h0);
		send_cmd(OP_SET_INVERT, r[3:0]);
		send_cmd(OP_SET_EDGE, r[3:0] ^ 4'b0110);
		repeat (GUARD) step();
		window_packet(200, 1'b0, 1'b0);
		end_test("inversion and edge masks");

		send_cmd(OP_CLEAR, 4'h0);
		window_packet(150, 1'b0, 1'b0);
		window_packet(150, 1'b0, 1'b0);
		end_test("clear and accumulation");

		send_cmd(OP_CLEAR, 4'h0);
		send_cmd(OP_SET_INVERT, 4'h0);
		send_cmd(OP_SET_EDGE, 4'h0);
		repeat (GUARD) step();
		window_packet(65540, 1'b1, 1'b0);
		check_val("overflow[0]", 32'(overflow[0]), 32'h1);
		send_cmd(OP_CLEAR, 4'h0);
		step();
		check_val("overflow", 32'(overflow), 32'h0);
		end_test("saturation and overflow");

		window_packet(120, 1'b0, 1'b1);
		for (int t = 0; t < 10; t++) begin
			step();
			check_val("integrating", 32'(integrating), 32'h0);
			check_val("tx_active", 32'(tx_active), 32'h0);
		end
		end_test("back-pressure and ignored commands");

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests, failed, checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

/* corr_top.f */
corr_pkg.sv
line_conditioner.sv
cmd_parser.sv
line_channel.sv
packet_tx.sv
corr_top.sv
corr_props.sv
corr_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= corr_tb
FILELIST  ?= corr_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
